/* Bender.yml */
package:
  name: geo_plotter

sources:
  - src/geo_pkg.sv
  - src/geo_line_if.sv
  - src/cmd_fifo.sv
  - src/geo_cmd_decoder.sv
  - src/line_generator.sv
  - src/draw_cmd_output.sv
  - src/geo_plotter.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_geo_plotter.sv

/* dv/geo_model.svh */
// reference model of the geometry unit: LFSR source, command decode, Bresenham and clipping
`ifndef GEO_MODEL_SVH
`define GEO_MODEL_SVH

logic [31:0]        lfsr_state;                   // galois lfsr
int                 mx [4];                       // model x0..x3
int                 my [4];                       // model y0..y3
int                 m_clip_x;
int                 m_clip_y;
logic [7:0]         m_pen;
geo_pkg::draw_cmd_t exp_q [$];                    // expected draw commands in order

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

function automatic void model_reset();
  for (int i = 0; i < 4; i++) begin
    mx[i] = 0;
    my[i] = 0;
  end
  m_clip_x = 0;                                   // clip starts as the point (0,0)
  m_clip_y = 0;
  m_pen    = '0;
  exp_q.delete();
endfunction

function automatic void expect_cmd(input geo_pkg::draw_func_e f, input logic [7:0] d8,
                                   input int wy, input int wx);
  geo_pkg::draw_cmd_t c;
  c.func   = f;
  c.data8  = d8;
  c.word_y = 12'(wy);
  c.word_x = 12'(wx);
  exp_q.push_back(c);
endfunction

// textbook bresenham, every point a..b inclusive, clipped points dropped
function automatic void model_line(input int ax, input int ay, input int bx, input int by);
  int x, y, dx, dy, sx, sy, err, e2;
  x   = ax;
  y   = ay;
  dx  = (bx > ax) ? bx - ax : ax - bx;
  dy  = (by > ay) ? by - ay : ay - by;
  sx  = (bx >= ax) ? 1 : -1;
  sy  = (by >= ay) ? 1 : -1;
  err = dx - dy;
  for (int n = 0; n < 1000; n++) begin
    if (x <= m_clip_x && y <= m_clip_y) expect_cmd(geo_pkg::px_write, m_pen, y, x);
    if (x == bx && y == by) break;
    e2 = 2 * err;
    if (e2 > -dy) begin
      err = err - dy;
      x   = x + sx;
    end
    if (e2 < dx) begin
      err = err + dx;
      y   = y + sy;
    end
  end
endfunction

function automatic void model_cmd(input logic [15:0] c);
  logic [7:0] op;
  logic [7:0] d8;
  int         k;
  op = c[15:8];
  d8 = c[7:0];
  if (op[7:6] == 2'b10) mx[op[5:4]] = c[11:0];
  else if (op[7:6] == 2'b11) my[op[5:4]] = c[11:0];
  else if (op[7:2] == 6'b011111) expect_cmd(geo_pkg::dst_addr, d8, my[op[1:0]], mx[op[1:0]]);
  else if (op[7:2] == 6'b011110) expect_cmd(geo_pkg::src_addr, d8, my[op[1:0]], mx[op[1:0]]);
  else if (op >= 112 && op <= 115) begin
    k = (op >= 114) ? 2 : 3;                      // 115/114 use x2/y2
    expect_cmd((op == 115 || op == 113) ? geo_pkg::dst_width : geo_pkg::src_width,
               d8, my[k], mx[k]);
  end else if (op >= 92 && op <= 95) begin
    k        = 95 - op;
    m_clip_x = mx[k];
    m_clip_y = my[k];
  end else if (op == 91 || op == 90) begin
    expect_cmd((op == 91) ? geo_pkg::rst_wr_mask : geo_pkg::rst_paste_mask, d8,
               {d8, d8[7:4]}, {d8[3:0], d8[7:4]});
  end else if (op[7:5] == 3'b000 && (op[2:0] == 1 || op[2:0] == 2)) begin
    m_pen = d8;
    if (op[2:0] == 1) model_line(mx[0], my[0], mx[0], my[0]);
    else model_line(mx[0], my[0], mx[1], my[1]);
  end
endfunction

`endif

/* dv/tb_geo_plotter.sv */
// testbench for the geometry command unit: random commands checked against a reference model
module tb_geo_plotter;

  logic                      clk;
  logic                      reset;
  logic                      cmd_valid;
  logic [geo_pkg::cmd_w-1:0] cmd_data;
  logic                      cmd_almost_full;
  logic                      draw_busy;
  logic                      draw_valid;
  geo_pkg::draw_cmd_t        draw_cmd;
  int                        busy_mode;           // 0 free, 1 random stall, 2 held
  int                        taken;               // commands accepted downstream

  `include "geo_model.svh"

  geo_plotter DUT (
    .clk             (clk),
    .reset           (reset),
    .cmd_valid       (cmd_valid),
    .cmd_data        (cmd_data),
    .cmd_almost_full (cmd_almost_full),
    .draw_busy       (draw_busy),
    .draw_valid      (draw_valid),
    .draw_cmd        (draw_cmd)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  function automatic logic next_busy();
    if (busy_mode == 0) return 1'b0;
    if (busy_mode == 2) return 1'b1;
    return (rand_bits(2) == 2'b11);               // stall about one cycle in four
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    cmd_valid <= 1'b0;
    draw_busy <= next_busy();
  endtask

  // host write, holding off while almost-full is seen
  task automatic send_cmd(input logic [15:0] c);
    int waited;
    waited = 0;
    @(posedge clk);
    draw_busy <= next_busy();
    while (cmd_almost_full) begin
      cmd_valid <= 1'b0;
      waited++;
      assert (waited < 5000) else fail_run("host write blocked by almost-full for too long");
      @(posedge clk);
      draw_busy <= next_busy();
    end
    cmd_valid <= 1'b1;
    cmd_data  <= c;
    model_cmd(c);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    idle_cycle();
    while (exp_q.size() != 0) begin
      waited++;
      assert (waited < 20000) else fail_run("expected draw commands never came out");
      idle_cycle();
    end
    repeat (30) idle_cycle();                     // window for stray outputs
  endtask

  function automatic logic [15:0] random_cmd();
    logic [3:0] kind;
    logic [1:0] idx;
    logic [7:0] d8;
    kind = rand_bits(4);
    idx  = rand_bits(2);
    d8   = rand_bits(8);
    case (kind)
      0, 1, 2: return {2'b10, idx, 6'b0, 6'(rand_bits(6))};   // coords kept in 0..63
      3, 4, 5: return {2'b11, idx, 6'b0, 6'(rand_bits(6))};
      6:       return {6'b011111, idx, d8};
      7:       return {6'b011110, idx, d8};
      8:       return {8'd112 + 8'(idx), d8};
      9:       return {8'd92 + 8'(idx), d8};
      10:      return {7'b0101101, idx[0], d8};               // 90 or 91
      11, 12:  return {5'b00000, 3'(kind - 4'd10), d8};       // pixel or line
      13:      return {3'b000, 2'(rand_bits(2)), 3'(rand_bits(3)), d8}; // any shape
      default: begin
        case (idx)
          0:       return {8'd32 + 8'(rand_bits(5)), d8};    // unknown codes
          1:       return {8'd96 + 8'(rand_bits(4)), d8};
          2:       return {8'd116 + 8'(rand_bits(2)), d8};
          default: return {8'd64 + 8'(rand_bits(4)), d8};
        endcase
      end
    endcase
  endfunction

  // ************************************************************
  // checker, sampled mid-cycle
  // ************************************************************
  always @(negedge clk) begin
    if (!reset) begin
      assert (!(draw_valid && draw_busy)) else fail_run("draw_valid high while draw_busy high");
      if (draw_valid) begin
        assert (exp_q.size() > 0)
          else fail_run($sformatf("unexpected draw command %h at time %0t", draw_cmd, $time));
        assert (draw_cmd === exp_q[0])
          else fail_run($sformatf("mismatch at time %0t: draw_cmd %h expected %h",
                                  $time, draw_cmd, exp_q[0]));
        void'(exp_q.pop_front());
        taken++;
      end
    end
  end

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd_data   = '0;
    draw_busy  = 1'b0;
    busy_mode  = 0;
    taken      = 0;
    lfsr_state = 32'h32ce;
    model_reset();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (!draw_valid && !cmd_almost_full) else fail_run("outputs not idle after reset");

    // directed pass over every configuration code
    for (int i = 0; i < 4; i++) begin
      send_cmd({2'b10, 2'(i), 6'b0, 6'(rand_bits(6))});
      send_cmd({2'b11, 2'(i), 6'b0, 6'(rand_bits(6))});
    end
    for (int i = 0; i < 4; i++) begin
      send_cmd({6'b011111, 2'(i), 8'(rand_bits(8))});
      send_cmd({6'b011110, 2'(i), 8'(rand_bits(8))});
      send_cmd({8'd112 + 8'(i), 8'(rand_bits(8))});
      send_cmd({8'd92 + 8'(i), 8'(rand_bits(8))});
    end
    send_cmd({8'd91, 8'(rand_bits(8))});
    send_cmd({8'd90, 8'(rand_bits(8))});
    wait_drain();

    // random mix under random stalls
    busy_mode = 1;
    repeat (400) send_cmd(random_cmd());
    send_cmd({8'd91, 8'(rand_bits(8))});          // last one has output, fifo empty after
    wait_drain();

    // almost-full threshold with the writer stalled
    busy_mode = 2;
    idle_cycle();
    for (int k = 1; k <= 56; k++) begin
      send_cmd({6'b011111, 2'(rand_bits(2)), 8'(rand_bits(8))});
      idle_cycle();                               // write k lands on this edge
      @(negedge clk);
      assert (cmd_almost_full == (k >= 56))
        else fail_run($sformatf("mismatch at time %0t: almost_full %b after write %0d",
                                $time, cmd_almost_full, k));
    end
    busy_mode = 1;
    wait_drain();

    assert (exp_q.size() == 0 && taken > 0) $display("TESTS PASSED");
    else fail_run("draw stream incomplete at end");
    $finish;
  end

endmodule

/* src/cmd_fifo.sv */
// show-ahead host command FIFO on a circular RAM, with almost-full back-pressure flag
module cmd_fifo #(
  parameter int depth  = geo_pkg::fifo_depth,
  parameter int margin = geo_pkg::fifo_margin
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      wr_en,        // host write strobe
  input  logic [geo_pkg::cmd_w-1:0] wr_data,
  input  logic                      rd_en,        // pop head entry
  output logic [geo_pkg::cmd_w-1:0] rd_data,      // head, valid while not empty
  output logic                      empty,
  output logic                      almost_full
);

  localparam int aw = $clog2(depth);              // pointer width
  localparam int cw = $clog2(depth + 1);          // count width

  logic [geo_pkg::cmd_w-1:0] mem [depth];         // command storage
  logic [aw-1:0]             wr_ptr;
  logic [aw-1:0]             rd_ptr;
  logic [cw-1:0]             count;               // entries stored
  logic                      full;
  logic                      do_wr;
  logic                      do_rd;

  assign full        = (count == cw'(depth));
  assign empty       = (count == '0);
  assign almost_full = (count >= cw'(depth - margin)); // straight off the count
  assign do_wr       = wr_en && !full;              // drop writes on overflow
  assign do_rd       = rd_en && !empty;
  assign rd_data     = mem[rd_ptr];                 // show-ahead read

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1; // wrap
      if (do_rd) rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                   // idle or write+read
      endcase
    end
  end

  // host must honour almost_full before the margin runs out
  a_no_overflow : assert property (@(posedge clk) disable iff (reset) !(wr_en && full));

  // decoder only pops a present command
  a_no_underflow : assert property (@(posedge clk) disable iff (reset) !(rd_en && empty));

endmodule

/* src/draw_cmd_output.sv */
// draw command output stage: clips generated points and registers the outgoing command
module draw_cmd_output (
  input  logic               clk,
  input  logic               reset,
  input  logic               draw_busy,           // downstream stall
  input  logic               cfg_valid,
  input  geo_pkg::draw_cmd_t cfg_cmd,
  input  logic               pt_valid,
  input  geo_pkg::coord_t    pt_x,
  input  geo_pkg::coord_t    pt_y,
  input  logic [7:0]         pen_color,
  input  geo_pkg::coord_t    clip_x,
  input  geo_pkg::coord_t    clip_y,
  output logic               draw_valid,
  output geo_pkg::draw_cmd_t draw_cmd
);

  logic pending;                                  // draw_cmd holds an untaken command
  logic in_clip;                                  // point inside clip rectangle

  assign in_clip    = (pt_x <= clip_x) && (pt_y <= clip_y);
  assign draw_valid = pending && !draw_busy;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (!draw_busy) begin
      pending <= cfg_valid || (pt_valid && in_clip); // clear when nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (!draw_busy) begin
      if (cfg_valid) begin
        draw_cmd <= cfg_cmd;
      end else if (pt_valid && in_clip) begin
        draw_cmd.func   <= geo_pkg::px_write;
        draw_cmd.data8  <= pen_color;
        draw_cmd.word_y <= pt_y;
        draw_cmd.word_x <= pt_x;
      end
    end
  end

  // decoder holds off pops while a line runs, so the sources never collide
  a_one_source : assert property (@(posedge clk) disable iff (reset) !(cfg_valid && pt_valid));

endmodule

/* src/geo_cmd_decoder.sv */
// command decoder: coordinate, clip and pen registers, configuration commands and line requests
module geo_cmd_decoder (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      draw_busy,    // downstream stall
  input  logic [geo_pkg::cmd_w-1:0] fifo_data,    // fifo head
  input  logic                      fifo_empty,
  output logic                      fifo_pop,
  geo_line_if.req                   line,
  output logic                      cfg_valid,    // configuration command pending
  output geo_pkg::draw_cmd_t        cfg_cmd,
  output logic [7:0]                pen_color,
  output geo_pkg::coord_t           clip_x,       // inclusive clip limits
  output geo_pkg::coord_t           clip_y
);

  logic [7:0]         op;                         // command byte
  logic [7:0]         data8;                      // low byte
  geo_pkg::coord_t    data12;                     // coordinate field
  geo_pkg::coord_t    x [4];                      // x0..x3
  geo_pkg::coord_t    y [4];                      // y0..y3
  logic [1:0]         sel;                        // x/y register index for this command
  logic               is_cfg;                     // command emits a draw command
  logic               set_x;
  logic               set_y;
  logic               set_clip;
  logic               is_draw;                    // pixel or line shape
  geo_pkg::draw_cmd_t nxt_cmd;

  assign op     = fifo_data[15:8];
  assign data8  = fifo_data[7:0];
  assign data12 = fifo_data[geo_pkg::coord_w-1:0];

  // pop only between lines and only on advance cycles
  assign fifo_pop   = !fifo_empty && !draw_busy && !line.busy;
  assign line.start = fifo_pop && is_draw;         // generator latches on the pop edge

  // pixel is a zero-length line at x0,y0
  assign line.ax = x[0];
  assign line.ay = y[0];
  assign line.bx = (op[2:0] == geo_pkg::shape_line) ? x[1] : x[0];
  assign line.by = (op[2:0] == geo_pkg::shape_line) ? y[1] : y[0];

  // ********************************************************
  // command decode
  // ********************************************************
  always_comb begin
    is_cfg         = 1'b0;
    set_x          = 1'b0;
    set_y          = 1'b0;
    set_clip       = 1'b0;
    is_draw        = 1'b0;
    sel            = op[1:0];                      // address commands index here
    nxt_cmd.func   = geo_pkg::px_write;
    nxt_cmd.data8  = data8;                        // every config carries the low byte
    nxt_cmd.word_y = y[sel];
    nxt_cmd.word_x = x[sel];
    if (op[7:6] == geo_pkg::op_set_x_top) begin
      set_x = 1'b1;
      sel   = op[5:4];
    end else if (op[7:6] == geo_pkg::op_set_y_top) begin
      set_y = 1'b1;
      sel   = op[5:4];
    end else if (op[7:2] == geo_pkg::op_dst_addr_hi) begin
      is_cfg       = 1'b1;
      nxt_cmd.func = geo_pkg::dst_addr;
    end else if (op[7:2] == geo_pkg::op_src_addr_hi) begin
      is_cfg       = 1'b1;
      nxt_cmd.func = geo_pkg::src_addr;
    end else if (op >= geo_pkg::op_width_base && op <= geo_pkg::op_width_base + 8'd3) begin
      is_cfg         = 1'b1;
      sel            = {1'b1, ~op[1]};               // 115/114 use x2/y2, 113/112 x3/y3
      nxt_cmd.func   = op[0] ? geo_pkg::dst_width : geo_pkg::src_width;
      nxt_cmd.word_y = y[{1'b1, ~op[1]}];
      nxt_cmd.word_x = x[{1'b1, ~op[1]}];
    end else if (op >= geo_pkg::op_clip_base && op <= geo_pkg::op_clip_base + 8'd3) begin
      set_clip = 1'b1;
      sel      = ~op[1:0];                         // code 95-k picks x[k],y[k]
    end else if (op == geo_pkg::op_rst_wr_mask || op == geo_pkg::op_rst_paste_mask) begin
      is_cfg         = 1'b1;
      nxt_cmd.func   = (op == geo_pkg::op_rst_wr_mask) ? geo_pkg::rst_wr_mask
                                                        : geo_pkg::rst_paste_mask;
      nxt_cmd.word_y = {data8, data8[7:4]};          // mask colors packed
      nxt_cmd.word_x = {4'h0, data8[3:0], data8[7:4]};
    end else if (op[7:5] == geo_pkg::op_draw_top) begin
      // other shapes fall through and are simply popped
      is_draw = (op[2:0] == geo_pkg::shape_pixel) || (op[2:0] == geo_pkg::shape_line);
    end
  end

  // ********************************************************
  // registers, updated on advance cycles only
  // ********************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        x[i] <= '0;
        y[i] <= '0;
      end
      clip_x    <= '0;                             // clip is the point (0,0)
      clip_y    <= '0;
      pen_color <= '0;
      cfg_valid <= 1'b0;
      cfg_cmd   <= '0;
    end else if (!draw_busy) begin
      cfg_valid <= fifo_pop && is_cfg;             // held through stalls
      if (fifo_pop) begin
        if (is_cfg) cfg_cmd <= nxt_cmd;
        if (set_x) x[sel] <= data12;
        if (set_y) y[sel] <= data12;
        if (set_clip) begin
          clip_x <= x[sel];
          clip_y <= y[sel];
        end
        if (is_draw) pen_color <= data8;           // color of the new shape
      end
    end
  end

  // the generator answers every request with busy on the next edge
  a_start_ack : assert property (@(posedge clk) disable iff (reset)
    line.start |=> line.busy);

endmodule

/* src/geo_line_if.sv */
// line request link between the command decoder and the Bresenham line generator
interface geo_line_if;

  logic            start;                         // one-cycle request pulse
  geo_pkg::coord_t ax;                            // start point
  geo_pkg::coord_t ay;
  geo_pkg::coord_t bx;                            // end point
  geo_pkg::coord_t by;
  logic            busy;                          // line in progress

  modport req (
    output start, ax, ay, bx, by,
    input  busy
  );

  modport gen (
    input  start, ax, ay, bx, by,
    output busy
  );

endinterface

/* src/geo_pkg.sv */
// geometry unit package: widths, host opcodes, draw functions and the draw command word
package geo_pkg;

  // ********************************************************
  // widths and sizes
  // ********************************************************
  localparam int coord_w     = 12;                // x/y coordinate width
  localparam int cmd_w       = 16;                // host command width
  localparam int fifo_depth  = 64;                // command fifo entries
  localparam int fifo_margin = 8;                 // free entries left at almost-full

  typedef logic [coord_w-1:0] coord_t;            // unsigned screen coordinate

  // ********************************************************
  // draw command output
  // ********************************************************
  typedef enum logic [3:0] {
    px_write       = 4'd1,                        // write pixel in pen color
    rst_wr_mask    = 4'd10,                       // reset write collision counter
    rst_paste_mask = 4'd11,                       // reset paste collision counter
    dst_width      = 4'd12,                       // destination raster width
    src_width      = 4'd13,                       // source raster width
    dst_addr       = 4'd14,                       // destination base address
    src_addr       = 4'd15                        // source base address
  } draw_func_e;

  typedef struct packed {
    draw_func_e  func;                            // bits 35:32
    logic [7:0]  data8;                           // color or mode byte
    coord_t      word_y;                          // bits 23:12
    coord_t      word_x;                          // bits 11:0
  } draw_cmd_t;

  // ********************************************************
  // host command byte, command bits 15..8
  // ********************************************************
  localparam logic [1:0] op_set_x_top      = 2'b10;     // x[idx] <= data12
  localparam logic [1:0] op_set_y_top      = 2'b11;     // y[idx] <= data12
  localparam logic [5:0] op_dst_addr_hi    = 6'b011111; // dst address from x[i],y[i]
  localparam logic [5:0] op_src_addr_hi    = 6'b011110; // src address from x[i],y[i]
  localparam logic [7:0] op_width_base     = 8'd112;    // 112..115 raster widths
  localparam logic [7:0] op_clip_base      = 8'd92;     // 92..95 clip from x[k],y[k]
  localparam logic [7:0] op_rst_wr_mask    = 8'd91;
  localparam logic [7:0] op_rst_paste_mask = 8'd90;
  localparam logic [2:0] op_draw_top       = 3'b000;    // shape in bits 10..8

  // kept shape numbers
  localparam logic [2:0] shape_pixel = 3'd1;
  localparam logic [2:0] shape_line  = 3'd2;

endpackage

/* src/geo_plotter.sv */
// geometry command unit top: command FIFO, decoder, line generator and draw output stage
module geo_plotter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cmd_valid,       // host write strobe
  input  logic [geo_pkg::cmd_w-1:0] cmd_data,
  output logic                      cmd_almost_full, // host back-pressure
  input  logic                      draw_busy,       // pixel writer stall
  output logic                      draw_valid,
  output geo_pkg::draw_cmd_t        draw_cmd
);

  logic [geo_pkg::cmd_w-1:0] fifo_head;          // show-ahead head entry
  logic                      fifo_empty;
  logic                      fifo_pop;
  logic                      cfg_valid;
  geo_pkg::draw_cmd_t        cfg_cmd;
  logic [7:0]                pen_color;
  geo_pkg::coord_t           clip_x;
  geo_pkg::coord_t           clip_y;
  logic                      pt_valid;
  geo_pkg::coord_t           pt_x;
  geo_pkg::coord_t           pt_y;

  geo_line_if line_bus ();                        // decoder to generator request

  cmd_fifo #(
    .depth  (geo_pkg::fifo_depth),
    .margin (geo_pkg::fifo_margin)
  ) u_cmd_fifo (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (cmd_valid),
    .wr_data     (cmd_data),
    .rd_en       (fifo_pop),
    .rd_data     (fifo_head),
    .empty       (fifo_empty),
    .almost_full (cmd_almost_full)
  );

  geo_cmd_decoder u_decoder (
    .clk        (clk),
    .reset      (reset),
    .draw_busy  (draw_busy),
    .fifo_data  (fifo_head),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .line       (line_bus.req),
    .cfg_valid  (cfg_valid),
    .cfg_cmd    (cfg_cmd),
    .pen_color  (pen_color),
    .clip_x     (clip_x),
    .clip_y     (clip_y)
  );

  line_generator u_line_gen (
    .clk       (clk),
    .reset     (reset),
    .draw_busy (draw_busy),
    .line      (line_bus.gen),
    .pt_valid  (pt_valid),
    .pt_x      (pt_x),
    .pt_y      (pt_y)
  );

  draw_cmd_output u_output (
    .clk        (clk),
    .reset      (reset),
    .draw_busy  (draw_busy),
    .cfg_valid  (cfg_valid),
    .cfg_cmd    (cfg_cmd),
    .pt_valid   (pt_valid),
    .pt_x       (pt_x),
    .pt_y       (pt_y),
    .pen_color  (pen_color),
    .clip_x     (clip_x),
    .clip_y     (clip_y),
    .draw_valid (draw_valid),
    .draw_cmd   (draw_cmd)
  );

endmodule

/* src/line_generator.sv */
// Bresenham line generator: steps one point per advance cycle from a to b inclusive
module line_generator (
  input  logic            clk,
  input  logic            reset,
  input  logic            draw_busy,              // stall while high
  geo_line_if.gen         line,
  output logic            pt_valid,               // point on pt_x/pt_y this cycle
  output geo_pkg::coord_t pt_x,
  output geo_pkg::coord_t pt_y
);

  geo_pkg::coord_t                  cur_x;        // current point
  geo_pkg::coord_t                  cur_y;
  geo_pkg::coord_t                  end_x;        // last point
  geo_pkg::coord_t                  end_y;
  geo_pkg::coord_t                  dx_abs;       // |bx-ax| of the request
  geo_pkg::coord_t                  dy_abs;
  logic                             x_inc;        // step direction, 1 = up
  logic                             y_inc;
  logic signed [geo_pkg::coord_w+1:0] dx;         // two spare bits for 2*err
  logic signed [geo_pkg::coord_w+1:0] dy;
  logic signed [geo_pkg::coord_w+1:0] err;
  logic signed [geo_pkg::coord_w+1:0] e2;
  logic                             step_x;
  logic                             step_y;
  logic                             at_end;
  logic                             advance;

  assign dx_abs  = (line.bx >= line.ax) ? line.bx - line.ax : line.ax - line.bx;
  assign dy_abs  = (line.by >= line.ay) ? line.by - line.ay : line.ay - line.by;
  assign e2      = err <<< 1;
  assign step_x  = (e2 > -dy);
  assign step_y  = (e2 < dx);
  assign at_end  = (cur_x == end_x) && (cur_y == end_y);
  assign advance = line.busy && !draw_busy;

  assign pt_valid = advance;                      // one point per advance cycle
  assign pt_x     = cur_x;
  assign pt_y     = cur_y;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      line.busy <= 1'b0;
    end else if (line.start) begin
      line.busy <= 1'b1;
    end else if (advance && at_end) begin
      line.busy <= 1'b0;                          // last point just went out
    end
  end

  // ********************************************************
  // stepper datapath
  // ********************************************************
  always_ff @(posedge clk) begin
    if (line.start) begin
      cur_x <= line.ax;
      cur_y <= line.ay;
      end_x <= line.bx;
      end_y <= line.by;
      x_inc <= (line.bx >= line.ax);
      y_inc <= (line.by >= line.ay);
      dx    <= {2'b00, dx_abs};
      dy    <= {2'b00, dy_abs};
      err   <= $signed({2'b00, dx_abs}) - $signed({2'b00, dy_abs}); // err = dx - dy
    end else if (advance && !at_end) begin
      if (step_x) cur_x <= x_inc ? cur_x + 1'b1 : cur_x - 1'b1;
      if (step_y) cur_y <= y_inc ? cur_y + 1'b1 : cur_y - 1'b1;
      err <= err - (step_x ? dy : '0) + (step_y ? dx : '0);
    end
  end

  // every step short of the end point moves on at least one axis
  a_step_moves : assert property (@(posedge clk) disable iff (reset)
    advance && !at_end |-> (step_x || step_y));

endmodule

/* vlog.f */
+incdir+dv
src/geo_pkg.sv
src/geo_line_if.sv
src/cmd_fifo.sv
src/geo_cmd_decoder.sv
src/line_generator.sv
src/draw_cmd_output.sv
src/geo_plotter.sv
dv/tb_geo_plotter.sv
